//--- rv_pkg.sv
package rv_pkg;

  // datapath and register index widths
  localparam int XLEN = 32;
  localparam int REG_IDX_W = 5;
  // one register per index value
  localparam int NUM_REGS = 1 << REG_IDX_W;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] insn_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes that the pipeline executes
  localparam opcode_t OPCODE_LUI = 7'b01_101_11;
  localparam opcode_t OPCODE_REG_IMM = 7'b00_100_11;
  localparam opcode_t OPCODE_REG_REG = 7'b01_100_11;

  // addi, add and sub all share funct3 zero
  localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
  localparam funct7_t FUNCT7_ADD = 7'h00;
  localparam funct7_t FUNCT7_SUB = 7'h20;

  // program counter
  localparam word_t PC_STEP = 32'd4;
  localparam word_t RESET_PC = 32'd0;

  // status of the slot that reaches writeback
  typedef enum logic [2:0] {
    // never seen once reset has drained
    CYCLE_INVALID = 3'd0,
    // bubble left behind by reset
    CYCLE_RESET = 3'd1,
    // a real instruction
    CYCLE_NO_STALL = 3'd2
  } cycle_status_e;

endpackage

//--- reg_file.sv
module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  // both read ports are combinational
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // single write port, takes effect at the next edge
  // x0 stays zero since we is never raised for index 0
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- fetch_stage.sv
module fetch_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         insn_from_imem,
  output rv_pkg::word_t         pc_to_imem,
  output rv_pkg::word_t         d_pc,
  output rv_pkg::insn_t         d_insn,
  output rv_pkg::cycle_status_e d_status
);
  import rv_pkg::*;

  // program counter, no branches so it only ever steps forward
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_to_imem <= RESET_PC;
    end else begin
      pc_to_imem <= pc_to_imem + PC_STEP;
    end
  end

  // fetch to decode register
  // imem answers in the same cycle, so the word is captured here
  always_ff @(posedge clk) begin
    if (rst) begin
      d_pc     <= '0;
      d_insn   <= '0;
      // reset bubble travels down to writeback
      d_status <= CYCLE_RESET;
    end else begin
      d_pc     <= pc_to_imem;
      d_insn   <= insn_from_imem;
      d_status <= CYCLE_NO_STALL;
    end
  end

endmodule

//--- decode_stage.sv
module decode_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         d_pc,
  input  rv_pkg::insn_t         d_insn,
  input  rv_pkg::cycle_status_e d_status,
  input  rv_pkg::reg_idx_t      w_rd,
  input  rv_pkg::word_t         w_data,
  input  logic                  w_rd_we,
  output rv_pkg::word_t         x_pc,
  output rv_pkg::insn_t         x_insn,
  output rv_pkg::cycle_status_e x_status,
  output rv_pkg::reg_idx_t      x_rd,
  output rv_pkg::reg_idx_t      x_rs1,
  output rv_pkg::reg_idx_t      x_rs2,
  output rv_pkg::word_t         x_rs1_data,
  output rv_pkg::word_t         x_rs2_data
);
  import rv_pkg::*;

  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rf_rs1_data;
  word_t    rf_rs2_data;
  word_t    rs1_data;
  word_t    rs2_data;

  // register fields sit at fixed positions in every format
  assign rd  = d_insn[11:7];
  assign rs1 = d_insn[19:15];
  assign rs2 = d_insn[24:20];

  // write port is driven straight from the writeback register
  reg_file rf (
    .clk      (clk),
    .rst      (rst),
    .we       (w_rd_we),
    .rd       (w_rd),
    .rd_data  (w_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  // writeback to decode bypass
  // the file only updates at the edge, so a same-cycle write is taken here
  assign rs1_data = (w_rd_we && (w_rd == rs1)) ? w_data : rf_rs1_data;
  assign rs2_data = (w_rd_we && (w_rd == rs2)) ? w_data : rf_rs2_data;

  // decode to execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      x_pc       <= '0;
      x_insn     <= '0;
      x_status   <= CYCLE_RESET;
      x_rd       <= '0;
      x_rs1      <= '0;
      x_rs2      <= '0;
      x_rs1_data <= '0;
      x_rs2_data <= '0;
    end else begin
      x_pc       <= d_pc;
      x_insn     <= d_insn;
      x_status   <= d_status;
      x_rd       <= rd;
      x_rs1      <= rs1;
      x_rs2      <= rs2;
      x_rs1_data <= rs1_data;
      x_rs2_data <= rs2_data;
    end
  end

endmodule

//--- execute_stage.sv
module execute_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         x_pc,
  input  rv_pkg::insn_t         x_insn,
  input  rv_pkg::cycle_status_e x_status,
  input  rv_pkg::reg_idx_t      x_rd,
  input  rv_pkg::reg_idx_t      x_rs1,
  input  rv_pkg::reg_idx_t      x_rs2,
  input  rv_pkg::word_t         x_rs1_data,
  input  rv_pkg::word_t         x_rs2_data,
  input  rv_pkg::reg_idx_t      w_rd,
  input  rv_pkg::word_t         w_data,
  input  logic                  w_rd_we,
  output rv_pkg::word_t         m_pc,
  output rv_pkg::insn_t         m_insn,
  output rv_pkg::cycle_status_e m_status,
  output rv_pkg::reg_idx_t      m_rd,
  output rv_pkg::word_t         m_data,
  output logic                  m_rd_we
);
  import rv_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  word_t   imm_i;
  word_t   op_a;
  word_t   op_b;
  word_t   fwd_rs2;
  word_t   add_b;
  word_t   sum;
  word_t   result;
  logic    is_sub;
  logic    illegal;
  logic    rd_we;

  assign opcode = x_insn[6:0];
  assign funct3 = x_insn[14:12];
  assign funct7 = x_insn[31:25];
  // I-type immediate, sign extended
  assign imm_i  = {{20{x_insn[31]}}, x_insn[31:20]};

  // operand bypass: memory is younger, so it wins over writeback
  // the decode value is only used when neither stage writes the register
  always_comb begin
    if (m_rd_we && (m_rd == x_rs1)) begin
      op_a = m_data;
    end else if (w_rd_we && (w_rd == x_rs1)) begin
      op_a = w_data;
    end else begin
      op_a = x_rs1_data;
    end
  end

  always_comb begin
    if (m_rd_we && (m_rd == x_rs2)) begin
      fwd_rs2 = m_data;
    end else if (w_rd_we && (w_rd == x_rs2)) begin
      fwd_rs2 = w_data;
    end else begin
      fwd_rs2 = x_rs2_data;
    end
  end

  // addi takes the immediate as second operand
  assign op_b   = (opcode == OPCODE_REG_IMM) ? imm_i : fwd_rs2;
  // sub is a + ~b + 1 on the same adder
  assign is_sub = (opcode == OPCODE_REG_REG) && (funct7 == FUNCT7_SUB);
  assign add_b  = is_sub ? ~op_b : op_b;
  assign sum    = op_a + add_b + word_t'(is_sub);

  // result select and illegal detection
  always_comb begin
    result  = '0;
    illegal = 1'b0;
    case (opcode)
      OPCODE_LUI: begin
        result = {x_insn[31:12], 12'b0};
      end
      OPCODE_REG_IMM: begin
        // only addi is supported among the reg-imm ops
        if (funct3 == FUNCT3_ADD_SUB) begin
          result = sum;
        end else begin
          illegal = 1'b1;
        end
      end
      OPCODE_REG_REG: begin
        if ((funct3 == FUNCT3_ADD_SUB) &&
            ((funct7 == FUNCT7_ADD) || (funct7 == FUNCT7_SUB))) begin
          result = sum;
        end else begin
          illegal = 1'b1;
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // write enable decided once here and carried down the pipe
  // x0 writes are dropped so later stages need not check rd
  assign rd_we = (x_status == CYCLE_NO_STALL) && !illegal && (x_rd != '0);

  // execute to memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      m_pc     <= '0;
      m_insn   <= '0;
      m_status <= CYCLE_RESET;
      m_rd     <= '0;
      m_data   <= '0;
      m_rd_we  <= 1'b0;
    end else begin
      m_pc     <= x_pc;
      m_insn   <= x_insn;
      m_status <= x_status;
      m_rd     <= x_rd;
      m_data   <= result;
      m_rd_we  <= rd_we;
    end
  end

endmodule

//--- retire_stage.sv
module retire_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         m_pc,
  input  rv_pkg::insn_t         m_insn,
  input  rv_pkg::cycle_status_e m_status,
  input  rv_pkg::reg_idx_t      m_rd,
  input  rv_pkg::word_t         m_data,
  input  logic                  m_rd_we,
  output rv_pkg::reg_idx_t      w_rd,
  output rv_pkg::word_t         w_data,
  output logic                  w_rd_we,
  output rv_pkg::word_t         trace_writeback_pc,
  output rv_pkg::insn_t         trace_writeback_insn,
  output rv_pkg::cycle_status_e trace_writeback_cycle_status,
  output rv_pkg::reg_idx_t      trace_writeback_rd,
  output rv_pkg::word_t         trace_writeback_data,
  output logic                  trace_writeback_we
);
  import rv_pkg::*;

  // memory to writeback register
  // w_rd, w_data and w_rd_we feed the register file and both bypasses
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_writeback_pc           <= '0;
      trace_writeback_insn         <= '0;
      trace_writeback_cycle_status <= CYCLE_RESET;
      w_rd                         <= '0;
      w_data                       <= '0;
      w_rd_we                      <= 1'b0;
    end else begin
      trace_writeback_pc           <= m_pc;
      trace_writeback_insn         <= m_insn;
      trace_writeback_cycle_status <= m_status;
      w_rd                         <= m_rd;
      w_data                       <= m_data;
      w_rd_we                      <= m_rd_we;
    end
  end

  // trace shows exactly what goes into the register file this cycle
  assign trace_writeback_rd   = w_rd;
  assign trace_writeback_data = w_data;
  assign trace_writeback_we   = w_rd_we;

endmodule

//--- rv_pipeline.sv
module rv_pipeline (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::insn_t         insn_from_imem,
  output rv_pkg::word_t         pc_to_imem,
  output rv_pkg::word_t         trace_writeback_pc,
  output rv_pkg::insn_t         trace_writeback_insn,
  output rv_pkg::cycle_status_e trace_writeback_cycle_status,
  output rv_pkg::reg_idx_t      trace_writeback_rd,
  output rv_pkg::word_t         trace_writeback_data,
  output logic                  trace_writeback_we
);
  import rv_pkg::*;

  // fetch to decode
  word_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  // decode to execute
  word_t         x_pc;
  insn_t         x_insn;
  cycle_status_e x_status;
  reg_idx_t      x_rd;
  reg_idx_t      x_rs1;
  reg_idx_t      x_rs2;
  word_t         x_rs1_data;
  word_t         x_rs2_data;
  // execute to retire
  word_t         m_pc;
  insn_t         m_insn;
  cycle_status_e m_status;
  reg_idx_t      m_rd;
  word_t         m_data;
  logic          m_rd_we;
  // writeback feedback to decode and execute
  reg_idx_t      w_rd;
  word_t         w_data;
  logic          w_rd_we;

  fetch_stage u_fetch (
    .clk            (clk),
    .rst            (rst),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .d_pc           (d_pc),
    .d_insn         (d_insn),
    .d_status       (d_status)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .d_pc       (d_pc),
    .d_insn     (d_insn),
    .d_status   (d_status),
    .w_rd       (w_rd),
    .w_data     (w_data),
    .w_rd_we    (w_rd_we),
    .x_pc       (x_pc),
    .x_insn     (x_insn),
    .x_status   (x_status),
    .x_rd       (x_rd),
    .x_rs1      (x_rs1),
    .x_rs2      (x_rs2),
    .x_rs1_data (x_rs1_data),
    .x_rs2_data (x_rs2_data)
  );

  execute_stage u_execute (
    .clk        (clk),
    .rst        (rst),
    .x_pc       (x_pc),
    .x_insn     (x_insn),
    .x_status   (x_status),
    .x_rd       (x_rd),
    .x_rs1      (x_rs1),
    .x_rs2      (x_rs2),
    .x_rs1_data (x_rs1_data),
    .x_rs2_data (x_rs2_data),
    .w_rd       (w_rd),
    .w_data     (w_data),
    .w_rd_we    (w_rd_we),
    .m_pc       (m_pc),
    .m_insn     (m_insn),
    .m_status   (m_status),
    .m_rd       (m_rd),
    .m_data     (m_data),
    .m_rd_we    (m_rd_we)
  );

  retire_stage u_retire (
    .clk                          (clk),
    .rst                          (rst),
    .m_pc                         (m_pc),
    .m_insn                       (m_insn),
    .m_status                     (m_status),
    .m_rd                         (m_rd),
    .m_data                       (m_data),
    .m_rd_we                      (m_rd_we),
    .w_rd                         (w_rd),
    .w_data                       (w_data),
    .w_rd_we                      (w_rd_we),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_data         (trace_writeback_data),
    .trace_writeback_we           (trace_writeback_we)
  );

endmodule

//--- tb_checker.sv
module tb_checker #(
  parameter int NUM_ROWS = 1,
  parameter int TABLE_DEPTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pkg::word_t         pc_to_imem,
  input  rv_pkg::word_t         trace_writeback_pc,
  input  rv_pkg::insn_t         trace_writeback_insn,
  input  rv_pkg::cycle_status_e trace_writeback_cycle_status,
  input  rv_pkg::reg_idx_t      trace_writeback_rd,
  input  rv_pkg::word_t         trace_writeback_data,
  input  logic                  trace_writeback_we,
  input  rv_pkg::insn_t         exp_insn [TABLE_DEPTH],
  input  logic                  exp_we   [TABLE_DEPTH],
  input  rv_pkg::reg_idx_t      exp_rd   [TABLE_DEPTH],
  input  rv_pkg::word_t         exp_data [TABLE_DEPTH],
  output logic                  all_retired,
  output int                    error_count,
  output int                    retired_count
);
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  // reset bubbles seen at the trace before the first instruction
  localparam int RESET_SLOTS = 4;
  localparam word_t PC_END = 32'(NUM_ROWS * 4);

  int       errors = 0;
  int       retired = 0;
  int       reset_slots = 0;
  logic     seen_insn = 1'b0;
  word_t    next_pc = '0;
  // fetch pc starts at zero after reset and steps one word per cycle
  word_t    next_fetch_pc = '0;
  logic [4:0] row;

  assign error_count   = errors;
  assign retired_count = retired;
  assign all_retired   = (retired >= NUM_ROWS);

  task automatic compare_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // a reset bubble shows zero on every trace field
  task automatic check_reset_slot();
    if (seen_insn) begin
      $display("reset bubble reached writeback at %0t ns after instructions retired", $time);
      errors++;
    end
    compare_value("trace_writeback_pc", '0, trace_writeback_pc);
    compare_value("trace_writeback_insn", '0, trace_writeback_insn);
    compare_value("trace_writeback_rd", '0, 32'(trace_writeback_rd));
    compare_value("trace_writeback_data", '0, trace_writeback_data);
    compare_value("trace_writeback_we", '0, 32'(trace_writeback_we));
    reset_slots++;
  endtask

  task automatic check_retired_slot();
    if (!seen_insn) begin
      seen_insn = 1'b1;
      if (reset_slots != RESET_SLOTS) begin
        $display("saw %0d reset bubbles before the first instruction instead of %0d",
                 reset_slots, RESET_SLOTS);
        errors++;
      end
    end
    // pc must advance by one word per cycle
    compare_value("trace_writeback_pc", next_pc, trace_writeback_pc);
    next_pc = trace_writeback_pc + 32'd4;
    if (trace_writeback_pc < PC_END) begin
      row = trace_writeback_pc[6:2];
      compare_value("trace_writeback_insn", exp_insn[row], trace_writeback_insn);
      compare_value("trace_writeback_we", 32'(exp_we[row]), 32'(trace_writeback_we));
      // rd and data only matter when the register file is written
      if (exp_we[row]) begin
        compare_value("trace_writeback_rd", 32'(exp_rd[row]), 32'(trace_writeback_rd));
        compare_value("trace_writeback_data", exp_data[row], trace_writeback_data);
      end
      retired++;
    end else begin
      // past the program the zero word is illegal
      compare_value("trace_writeback_insn", '0, trace_writeback_insn);
      compare_value("trace_writeback_we", '0, 32'(trace_writeback_we));
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      compare_value("pc_to_imem", next_fetch_pc, pc_to_imem);
      next_fetch_pc = next_fetch_pc + 32'd4;
      case (trace_writeback_cycle_status)
        CYCLE_RESET: check_reset_slot();
        CYCLE_NO_STALL: check_retired_slot();
        default: begin
          $display("Error at %0t ns: trace_writeback_cycle_status expected %0d, got %0d",
                   $time, CYCLE_NO_STALL, trace_writeback_cycle_status);
          errors++;
        end
      endcase
    end
  end

endmodule

//--- tb_rv_pipeline.sv
module tb_rv_pipeline;
  timeunit 1ns;
  timeprecision 1ns;
  import rv_pkg::*;

  localparam int NUM_ROWS = 22;
  localparam int TABLE_DEPTH = 32;
  localparam int TIMEOUT_CYCLES = 200;
  // fetches from this pc on get an illegal zero word
  localparam word_t PC_END = 32'(NUM_ROWS * 4);

  logic          clk;
  logic          rst;
  insn_t         insn_from_imem;
  word_t         pc_to_imem;
  word_t         trace_writeback_pc;
  insn_t         trace_writeback_insn;
  cycle_status_e trace_writeback_cycle_status;
  reg_idx_t      trace_writeback_rd;
  word_t         trace_writeback_data;
  logic          trace_writeback_we;

  // program table with one row per instruction and its expected writeback
  insn_t    prog_insn [TABLE_DEPTH];
  logic     prog_we   [TABLE_DEPTH];
  reg_idx_t prog_rd   [TABLE_DEPTH];
  word_t    prog_data [TABLE_DEPTH];
  logic [4:0] fill_row;

  logic all_retired;
  int   error_count;
  int   retired_count;
  int   cycles;
  logic timed_out;

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  rv_pipeline dut (
    .clk                          (clk),
    .rst                          (rst),
    .insn_from_imem               (insn_from_imem),
    .pc_to_imem                   (pc_to_imem),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_data         (trace_writeback_data),
    .trace_writeback_we           (trace_writeback_we)
  );

  tb_checker #(
    .NUM_ROWS    (NUM_ROWS),
    .TABLE_DEPTH (TABLE_DEPTH)
  ) chk (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_cycle_status (trace_writeback_cycle_status),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_data         (trace_writeback_data),
    .trace_writeback_we           (trace_writeback_we),
    .exp_insn                     (prog_insn),
    .exp_we                       (prog_we),
    .exp_rd                       (prog_rd),
    .exp_data                     (prog_data),
    .all_retired                  (all_retired),
    .error_count                  (error_count),
    .retired_count                (retired_count)
  );

  // instruction encoders for the three formats used
  function automatic insn_t lui_word(input reg_idx_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic insn_t imm_op_word(input logic [2:0] f3, input reg_idx_t rd,
                                        input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic insn_t reg_op_word(input logic [6:0] f7, input logic [2:0] f3,
                                        input reg_idx_t rd, input reg_idx_t rs1,
                                        input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  task automatic add_row(input insn_t insn, input logic we, input reg_idx_t rd,
                         input word_t data);
    prog_insn[fill_row] = insn;
    prog_we[fill_row]   = we;
    prog_rd[fill_row]   = rd;
    prog_data[fill_row] = data;
    fill_row = fill_row + 5'd1;
  endtask

  // expected values worked out by hand from the opcode rules
  task automatic load_program();
    fill_row = 5'd0;
    add_row(lui_word(5'd1, 20'h12345), 1'b1, 5'd1, 32'h1234_5000);
    add_row(imm_op_word(3'h0, 5'd2, 5'd0, 12'd100), 1'b1, 5'd2, 32'h0000_0064);
    // negative immediate with x2 from the memory stage
    add_row(imm_op_word(3'h0, 5'd3, 5'd2, 12'hffb), 1'b1, 5'd3, 32'h0000_005f);
    // back to back chain through the memory bypass
    add_row(reg_op_word(7'h00, 3'h0, 5'd4, 5'd3, 5'd2), 1'b1, 5'd4, 32'h0000_00c3);
    add_row(reg_op_word(7'h20, 3'h0, 5'd5, 5'd4, 5'd1), 1'b1, 5'd5, 32'hedcb_b0c3);
    add_row(reg_op_word(7'h00, 3'h0, 5'd6, 5'd5, 5'd5), 1'b1, 5'd6, 32'hdb97_6186);
    // gap of one so x7 comes from writeback
    add_row(imm_op_word(3'h0, 5'd7, 5'd0, 12'd7), 1'b1, 5'd7, 32'h0000_0007);
    add_row(lui_word(5'd10, 20'habcde), 1'b1, 5'd10, 32'habcd_e000);
    add_row(reg_op_word(7'h20, 3'h0, 5'd9, 5'd7, 5'd2), 1'b1, 5'd9, 32'hffff_ffa3);
    // gap of two so the sources are bypassed into decode
    add_row(imm_op_word(3'h0, 5'd11, 5'd0, 12'h7ff), 1'b1, 5'd11, 32'h0000_07ff);
    add_row(imm_op_word(3'h0, 5'd12, 5'd0, 12'h800), 1'b1, 5'd12, 32'hffff_f800);
    add_row(lui_word(5'd13, 20'h00001), 1'b1, 5'd13, 32'h0000_1000);
    add_row(reg_op_word(7'h00, 3'h0, 5'd14, 5'd11, 5'd11), 1'b1, 5'd14, 32'h0000_0ffe);
    add_row(reg_op_word(7'h20, 3'h0, 5'd15, 5'd12, 5'd1), 1'b1, 5'd15, 32'hedcb_a800);
    add_row(reg_op_word(7'h00, 3'h0, 5'd16, 5'd14, 5'd13), 1'b1, 5'd16, 32'h0000_1ffe);
    // x0 is never written and always reads zero
    add_row(imm_op_word(3'h0, 5'd0, 5'd0, 12'd5), 1'b0, 5'd0, 32'h0);
    add_row(reg_op_word(7'h00, 3'h0, 5'd17, 5'd0, 5'd1), 1'b1, 5'd17, 32'h1234_5000);
    // mul is not supported, so x18 keeps zero
    add_row(reg_op_word(7'h01, 3'h0, 5'd18, 5'd17, 5'd17), 1'b0, 5'd0, 32'h0);
    add_row(reg_op_word(7'h00, 3'h0, 5'd19, 5'd17, 5'd18), 1'b1, 5'd19, 32'h1234_5000);
    add_row(reg_op_word(7'h20, 3'h0, 5'd20, 5'd19, 5'd17), 1'b1, 5'd20, 32'h0);
    // xori is illegal as well
    add_row(imm_op_word(3'h4, 5'd21, 5'd1, 12'h001), 1'b0, 5'd0, 32'h0);
    add_row(imm_op_word(3'h0, 5'd22, 5'd21, 12'd1), 1'b1, 5'd22, 32'h0000_0001);
  endtask

  // imem model answering for the pc shown in this cycle
  task automatic drive_imem();
    if (pc_to_imem < PC_END) begin
      insn_from_imem = prog_insn[pc_to_imem[6:2]];
    end else begin
      insn_from_imem = '0;
    end
  endtask

  initial begin
    rst            = 1'b1;
    insn_from_imem = '0;
    timed_out      = 1'b0;
    cycles         = 0;
    load_program();
    // two rising edges in reset and release on the falling edge
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    drive_imem();
    while (!all_retired && (cycles < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      drive_imem();
      cycles++;
    end
    if (!all_retired) begin
      timed_out = 1'b1;
      $display("Timeout: only %0d of %0d instructions retired within %0d cycles",
               retired_count, NUM_ROWS, TIMEOUT_CYCLES);
    end
    $display("errors: %0d, timeouts: %0d, instructions retired: %0d of %0d",
             error_count, timed_out, retired_count, NUM_ROWS);
    if ((error_count == 0) && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- flist.f
rv_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
retire_stage.sv
rv_pipeline.sv
tb_checker.sv
tb_rv_pipeline.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_rv_pipeline -f flist.f -o sim_tb_rv_pipeline

./obj_dir/sim_tb_rv_pipeline | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
exit 0
